// File: verilog/csr_pkg.sv
package csr_pkg;

    typedef logic [13:0] csr_num_t;
    typedef logic [31:0] csr_word_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [1:0]  plv_t;
    // SWI1..0, HWI7..0, reserved, timer, IPI
    typedef logic [12:0] int_vec_t;

    // Register numbers
    localparam csr_num_t CSR_CRMD   = 14'h0;
    localparam csr_num_t CSR_PRMD   = 14'h1;
    localparam csr_num_t CSR_ECFG   = 14'h4;
    localparam csr_num_t CSR_ESTAT  = 14'h5;
    localparam csr_num_t CSR_ERA    = 14'h6;
    localparam csr_num_t CSR_BADV   = 14'h7;
    localparam csr_num_t CSR_EENTRY = 14'hc;
    localparam csr_num_t CSR_SAVE0  = 14'h30;
    localparam csr_num_t CSR_SAVE1  = 14'h31;
    localparam csr_num_t CSR_SAVE2  = 14'h32;
    localparam csr_num_t CSR_SAVE3  = 14'h33;
    localparam csr_num_t CSR_TCFG   = 14'h41;
    localparam csr_num_t CSR_TVAL   = 14'h42;
    localparam csr_num_t CSR_TICLR  = 14'h44;

    // Field positions
    localparam int CRMD_PLV_LSB      = 0;
    localparam int CRMD_IE_BIT       = 2;
    localparam int PRMD_PPLV_LSB     = 0;
    localparam int PRMD_PIE_BIT      = 2;
    localparam int ESTAT_ECODE_LSB   = 16;
    localparam int ESTAT_ESUB_LSB    = 22;
    localparam int EENTRY_VA_LSB     = 6;
    localparam int TCFG_EN_BIT       = 0;
    localparam int TCFG_PERIODIC_BIT = 1;
    localparam int TCFG_INITV_LSB    = 2;
    localparam int TICLR_CLR_BIT     = 0;
    localparam int TIMER_IRQ_BIT     = 11;
    localparam int IPI_IRQ_BIT       = 12;

    // LIE bit 10 is reserved
    localparam csr_word_t ECFG_LIE_MASK = 32'h0000_1bff;

    localparam ecode_t    ECODE_ADE     = 6'h08;
    localparam ecode_t    ECODE_ALE     = 6'h09;
    localparam esubcode_t ESUBCODE_ADEF = 9'h0;

    // Counter value of a stopped timer
    localparam csr_word_t TIMER_IDLE = 32'hffff_ffff;

    function automatic csr_word_t masked_merge(
        input csr_word_t old_value,
        input csr_word_t wmask,
        input csr_word_t wvalue
    );
        return (wmask & wvalue) | (~wmask & old_value);
    endfunction

endpackage

// File: verilog/csr_exc_regs.sv
module csr_exc_regs (
    input  logic                  clk,
    input  logic                  resetn,
    input  csr_pkg::csr_num_t     csr_num,
    input  logic                  csr_we,
    input  csr_pkg::csr_word_t    csr_wmask,
    input  csr_pkg::csr_word_t    csr_wvalue,
    input  logic                  wb_ex,
    input  logic                  ertn_flush,
    input  csr_pkg::ecode_t       wb_ecode,
    input  csr_pkg::esubcode_t    wb_esubcode,
    input  csr_pkg::csr_word_t    wb_pc,
    input  csr_pkg::csr_word_t    wb_vaddr,
    output csr_pkg::csr_word_t    crmd_word,
    output csr_pkg::csr_word_t    prmd_word,
    output csr_pkg::csr_word_t    era_word,
    output csr_pkg::csr_word_t    eentry_word,
    output csr_pkg::csr_word_t    badv_word,
    output csr_pkg::csr_word_t    save_word0,
    output csr_pkg::csr_word_t    save_word1,
    output csr_pkg::csr_word_t    save_word2,
    output csr_pkg::csr_word_t    save_word3,
    output csr_pkg::ecode_t       estat_ecode,
    output csr_pkg::esubcode_t    estat_esubcode,
    output logic                  crmd_ie,
    output csr_pkg::csr_word_t    ex_entry
);
    import csr_pkg::*;

    plv_t                       crmd_plv;
    plv_t                       prmd_pplv;
    logic                       prmd_pie;
    logic [31:EENTRY_VA_LSB]    eentry_va;
    csr_word_t                  save_q [4];
    csr_word_t                  crmd_next;
    csr_word_t                  prmd_next;
    csr_word_t                  eentry_next;
    logic                       addr_err;

    assign crmd_next   = masked_merge(crmd_word, csr_wmask, csr_wvalue);
    assign prmd_next   = masked_merge(prmd_word, csr_wmask, csr_wvalue);
    assign eentry_next = masked_merge(eentry_word, csr_wmask, csr_wvalue);

    // Only ADE and ALE record a bad address here
    assign addr_err = (wb_ecode == ECODE_ADE) || (wb_ecode == ECODE_ALE);

    // Exception clears PLV/IE, ertn restores them from PRMD
    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (wb_ex) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (csr_we && csr_num == CSR_CRMD) begin
            crmd_plv <= crmd_next[CRMD_PLV_LSB +: $bits(plv_t)];
            crmd_ie  <= crmd_next[CRMD_IE_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
        end else if (wb_ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (csr_we && csr_num == CSR_PRMD) begin
            prmd_pplv <= prmd_next[PRMD_PPLV_LSB +: $bits(plv_t)];
            prmd_pie  <= prmd_next[PRMD_PIE_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            estat_ecode    <= '0;
            estat_esubcode <= '0;
        end else if (wb_ex) begin
            estat_ecode    <= wb_ecode;
            estat_esubcode <= wb_esubcode;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            era_word <= '0;
        end else if (wb_ex) begin
            era_word <= wb_pc;
        end else if (csr_we && csr_num == CSR_ERA) begin
            era_word <= masked_merge(era_word, csr_wmask, csr_wvalue);
        end
    end

    // Fetch-side ADE reports the PC, the rest the data address
    always_ff @(posedge clk) begin
        if (!resetn) begin
            badv_word <= '0;
        end else if (wb_ex) begin
            if (addr_err) begin
                if (wb_ecode == ECODE_ADE && wb_esubcode == ESUBCODE_ADEF) begin
                    badv_word <= wb_pc;
                end else begin
                    badv_word <= wb_vaddr;
                end
            end
        end else if (csr_we && csr_num == CSR_BADV) begin
            badv_word <= masked_merge(badv_word, csr_wmask, csr_wvalue);
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            eentry_va <= '0;
        end else if (csr_we && csr_num == CSR_EENTRY) begin
            eentry_va <= eentry_next[31:EENTRY_VA_LSB];
        end
    end

    for (genvar i = 0; i < 4; i++) begin : g_save
        always_ff @(posedge clk) begin
            if (!resetn) begin
                save_q[i] <= '0;
            end else if (csr_we && csr_num == CSR_SAVE0 + csr_num_t'(i)) begin
                save_q[i] <= masked_merge(save_q[i], csr_wmask, csr_wvalue);
            end
        end
    end

    always_comb begin
        crmd_word = '0;
        crmd_word[CRMD_PLV_LSB +: $bits(plv_t)] = crmd_plv;
        crmd_word[CRMD_IE_BIT] = crmd_ie;
        prmd_word = '0;
        prmd_word[PRMD_PPLV_LSB +: $bits(plv_t)] = prmd_pplv;
        prmd_word[PRMD_PIE_BIT] = prmd_pie;
    end

    assign eentry_word = {eentry_va, {EENTRY_VA_LSB{1'b0}}};
    assign ex_entry    = eentry_word;
    assign save_word0  = save_q[0];
    assign save_word1  = save_q[1];
    assign save_word2  = save_q[2];
    assign save_word3  = save_q[3];

endmodule

// File: verilog/csr_timer.sv
module csr_timer (
    input  logic                  clk,
    input  logic                  resetn,
    input  csr_pkg::csr_num_t     csr_num,
    input  logic                  csr_we,
    input  csr_pkg::csr_word_t    csr_wmask,
    input  csr_pkg::csr_word_t    csr_wvalue,
    output csr_pkg::csr_word_t    tcfg_word,
    output csr_pkg::csr_word_t    tval_word,
    output logic                  timer_fire
);
    import csr_pkg::*;

    csr_word_t tcfg_next;
    csr_word_t load_value;
    csr_word_t reload_value;
    csr_word_t count;
    logic      tcfg_wr;
    logic      timer_en;

    assign tcfg_wr   = csr_we && (csr_num == CSR_TCFG);
    assign tcfg_next = masked_merge(tcfg_word, csr_wmask, csr_wvalue);
    assign timer_en  = tcfg_word[TCFG_EN_BIT];

    // INITV sits at bit 2, so the start value is INITV*4
    assign load_value   = {tcfg_next[31:TCFG_INITV_LSB], {TCFG_INITV_LSB{1'b0}}};
    assign reload_value = {tcfg_word[31:TCFG_INITV_LSB], {TCFG_INITV_LSB{1'b0}}};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            tcfg_word <= '0;
        end else if (tcfg_wr) begin
            tcfg_word <= tcfg_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            count <= TIMER_IDLE;
        end else if (tcfg_wr && tcfg_next[TCFG_EN_BIT]) begin
            count <= load_value;
        end else if (timer_en && count != TIMER_IDLE) begin
            if (count == '0 && tcfg_word[TCFG_PERIODIC_BIT]) begin
                count <= reload_value;
            end else begin
                // One-shot wraps from 0 to idle and stops there
                count <= count - 32'd1;
            end
        end
    end

    assign timer_fire = timer_en && (count == '0);
    assign tval_word  = count;

endmodule

// File: verilog/csr_int_ctrl.sv
module csr_int_ctrl (
    input  logic                  clk,
    input  logic                  resetn,
    input  csr_pkg::csr_num_t     csr_num,
    input  logic                  csr_we,
    input  csr_pkg::csr_word_t    csr_wmask,
    input  csr_pkg::csr_word_t    csr_wvalue,
    input  logic [7:0]            hw_int_in,
    input  logic                  ipi_int_in,
    input  logic                  timer_fire,
    input  logic                  crmd_ie,
    output csr_pkg::csr_word_t    ecfg_word,
    output csr_pkg::int_vec_t     estat_is,
    output logic                  has_int
);
    import csr_pkg::*;

    int_vec_t   ecfg_lie;
    logic [1:0] is_sw;
    logic [7:0] is_hw;
    logic       is_timer;
    logic       is_ipi;
    csr_word_t  ecfg_next;
    csr_word_t  estat_next;
    csr_word_t  ticlr_next;
    logic       timer_clr;

    assign ecfg_next  = masked_merge(ecfg_word, csr_wmask, csr_wvalue) & ECFG_LIE_MASK;
    assign estat_next = masked_merge(csr_word_t'(is_sw), csr_wmask, csr_wvalue);
    // TICLR holds no state and always reads zero
    assign ticlr_next = masked_merge('0, csr_wmask, csr_wvalue);
    assign timer_clr  = csr_we && (csr_num == CSR_TICLR) && ticlr_next[TICLR_CLR_BIT];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ecfg_lie <= '0;
            is_sw    <= '0;
            is_hw    <= '0;
            is_timer <= 1'b0;
            is_ipi   <= 1'b0;
        end else begin
            if (csr_we && csr_num == CSR_ECFG) begin
                ecfg_lie <= ecfg_next[$bits(int_vec_t)-1:0];
            end
            if (csr_we && csr_num == CSR_ESTAT) begin
                is_sw <= estat_next[1:0];
            end
            is_hw  <= hw_int_in;
            is_ipi <= ipi_int_in;
            // A fire in the clearing cycle keeps the bit set
            if (timer_fire) begin
                is_timer <= 1'b1;
            end else if (timer_clr) begin
                is_timer <= 1'b0;
            end
        end
    end

    always_comb begin
        estat_is = '0;
        estat_is[1:0] = is_sw;
        estat_is[9:2] = is_hw;
        estat_is[TIMER_IRQ_BIT] = is_timer;
        estat_is[IPI_IRQ_BIT] = is_ipi;
    end

    assign ecfg_word = csr_word_t'(ecfg_lie);
    assign has_int   = crmd_ie && (|(estat_is & ecfg_lie));

endmodule

// File: verilog/csr_read_mux.sv
module csr_read_mux (
    input  csr_pkg::csr_num_t     csr_num,
    input  csr_pkg::csr_word_t    crmd_word,
    input  csr_pkg::csr_word_t    prmd_word,
    input  csr_pkg::csr_word_t    ecfg_word,
    input  csr_pkg::int_vec_t     estat_is,
    input  csr_pkg::ecode_t       estat_ecode,
    input  csr_pkg::esubcode_t    estat_esubcode,
    input  csr_pkg::csr_word_t    era_word,
    input  csr_pkg::csr_word_t    badv_word,
    input  csr_pkg::csr_word_t    eentry_word,
    input  csr_pkg::csr_word_t    save_word0,
    input  csr_pkg::csr_word_t    save_word1,
    input  csr_pkg::csr_word_t    save_word2,
    input  csr_pkg::csr_word_t    save_word3,
    input  csr_pkg::csr_word_t    tcfg_word,
    input  csr_pkg::csr_word_t    tval_word,
    output csr_pkg::csr_word_t    csr_rvalue
);
    import csr_pkg::*;

    csr_word_t estat_word;

    // ESTAT from the interrupt block and the exception block
    always_comb begin
        estat_word = '0;
        estat_word[$bits(int_vec_t)-1:0] = estat_is;
        estat_word[ESTAT_ECODE_LSB +: $bits(ecode_t)] = estat_ecode;
        estat_word[ESTAT_ESUB_LSB +: $bits(esubcode_t)] = estat_esubcode;
    end

    always_comb begin
        case (csr_num)
            CSR_CRMD:   csr_rvalue = crmd_word;
            CSR_PRMD:   csr_rvalue = prmd_word;
            CSR_ECFG:   csr_rvalue = ecfg_word;
            CSR_ESTAT:  csr_rvalue = estat_word;
            CSR_ERA:    csr_rvalue = era_word;
            CSR_BADV:   csr_rvalue = badv_word;
            CSR_EENTRY: csr_rvalue = eentry_word;
            CSR_SAVE0:  csr_rvalue = save_word0;
            CSR_SAVE1:  csr_rvalue = save_word1;
            CSR_SAVE2:  csr_rvalue = save_word2;
            CSR_SAVE3:  csr_rvalue = save_word3;
            CSR_TCFG:   csr_rvalue = tcfg_word;
            CSR_TVAL:   csr_rvalue = tval_word;
            CSR_TICLR:  csr_rvalue = '0;
            default:    csr_rvalue = '0;
        endcase
    end

endmodule

// File: verilog/csr_top.sv
module csr_top (
    input  logic                  clk,
    input  logic                  resetn,
    input  csr_pkg::csr_num_t     csr_num,
    input  logic                  csr_we,
    input  csr_pkg::csr_word_t    csr_wmask,
    input  csr_pkg::csr_word_t    csr_wvalue,
    input  logic                  wb_ex,
    input  logic                  ertn_flush,
    input  csr_pkg::ecode_t       wb_ecode,
    input  csr_pkg::esubcode_t    wb_esubcode,
    input  csr_pkg::csr_word_t    wb_pc,
    input  csr_pkg::csr_word_t    wb_vaddr,
    input  logic [7:0]            hw_int_in,
    input  logic                  ipi_int_in,
    output csr_pkg::csr_word_t    csr_rvalue,
    output csr_pkg::csr_word_t    ex_entry,
    output logic                  has_int
);
    import csr_pkg::*;

    csr_word_t crmd_word;
    csr_word_t prmd_word;
    csr_word_t era_word;
    csr_word_t eentry_word;
    csr_word_t badv_word;
    csr_word_t save_word0;
    csr_word_t save_word1;
    csr_word_t save_word2;
    csr_word_t save_word3;
    csr_word_t ecfg_word;
    csr_word_t tcfg_word;
    csr_word_t tval_word;
    ecode_t    estat_ecode;
    esubcode_t estat_esubcode;
    int_vec_t  estat_is;
    logic      crmd_ie;
    logic      timer_fire;

    csr_exc_regs i_exc_regs (
        .clk            (clk),
        .resetn         (resetn),
        .csr_num        (csr_num),
        .csr_we         (csr_we),
        .csr_wmask      (csr_wmask),
        .csr_wvalue     (csr_wvalue),
        .wb_ex          (wb_ex),
        .ertn_flush     (ertn_flush),
        .wb_ecode       (wb_ecode),
        .wb_esubcode    (wb_esubcode),
        .wb_pc          (wb_pc),
        .wb_vaddr       (wb_vaddr),
        .crmd_word      (crmd_word),
        .prmd_word      (prmd_word),
        .era_word       (era_word),
        .eentry_word    (eentry_word),
        .badv_word      (badv_word),
        .save_word0     (save_word0),
        .save_word1     (save_word1),
        .save_word2     (save_word2),
        .save_word3     (save_word3),
        .estat_ecode    (estat_ecode),
        .estat_esubcode (estat_esubcode),
        .crmd_ie        (crmd_ie),
        .ex_entry       (ex_entry)
    );

    csr_timer i_timer (
        .clk        (clk),
        .resetn     (resetn),
        .csr_num    (csr_num),
        .csr_we     (csr_we),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .tcfg_word  (tcfg_word),
        .tval_word  (tval_word),
        .timer_fire (timer_fire)
    );

    csr_int_ctrl i_int_ctrl (
        .clk        (clk),
        .resetn     (resetn),
        .csr_num    (csr_num),
        .csr_we     (csr_we),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .hw_int_in  (hw_int_in),
        .ipi_int_in (ipi_int_in),
        .timer_fire (timer_fire),
        .crmd_ie    (crmd_ie),
        .ecfg_word  (ecfg_word),
        .estat_is   (estat_is),
        .has_int    (has_int)
    );

    csr_read_mux i_read_mux (
        .csr_num        (csr_num),
        .crmd_word      (crmd_word),
        .prmd_word      (prmd_word),
        .ecfg_word      (ecfg_word),
        .estat_is       (estat_is),
        .estat_ecode    (estat_ecode),
        .estat_esubcode (estat_esubcode),
        .era_word       (era_word),
        .badv_word      (badv_word),
        .eentry_word    (eentry_word),
        .save_word0     (save_word0),
        .save_word1     (save_word1),
        .save_word2     (save_word2),
        .save_word3     (save_word3),
        .tcfg_word      (tcfg_word),
        .tval_word      (tval_word),
        .csr_rvalue     (csr_rvalue)
    );

endmodule

// File: sim/csr_checker.sv
module csr_checker (
    input  logic                  clk,
    input  logic                  resetn,
    input  csr_pkg::csr_num_t     csr_num,
    input  logic                  csr_we,
    input  csr_pkg::csr_word_t    csr_wmask,
    input  csr_pkg::csr_word_t    csr_wvalue,
    input  logic                  wb_ex,
    input  logic                  ertn_flush,
    input  csr_pkg::ecode_t       wb_ecode,
    input  csr_pkg::esubcode_t    wb_esubcode,
    input  csr_pkg::csr_word_t    wb_pc,
    input  csr_pkg::csr_word_t    wb_vaddr,
    input  logic [7:0]            hw_int_in,
    input  logic                  ipi_int_in,
    input  csr_pkg::csr_word_t    csr_rvalue,
    input  csr_pkg::csr_word_t    ex_entry,
    input  logic                  has_int,
    input  logic                  test_end,
    input  int                    test_id,
    output int                    tests_passed,
    output int                    tests_failed,
    output int                    error_count
);
    import csr_pkg::*;

    // Model state as it stands after the latest rising edge
    logic       model_valid = 1'b0;
    plv_t       plv;
    logic       ie;
    plv_t       pplv;
    logic       pie;
    ecode_t     ecode;
    esubcode_t  esub;
    csr_word_t  era;
    csr_word_t  badv;
    csr_word_t  eentry;
    csr_word_t  save0;
    csr_word_t  save1;
    csr_word_t  save2;
    csr_word_t  save3;
    csr_word_t  tcfg;
    csr_word_t  count;
    int_vec_t   lie;
    logic [1:0] is_sw;
    logic [7:0] is_hw;
    logic       is_timer;
    logic       is_ipi;
    int         passed_count = 0;
    int         failed_count = 0;
    int         mismatch_count = 0;
    int         test_errors = 0;

    assign tests_passed = passed_count;
    assign tests_failed = failed_count;
    assign error_count  = mismatch_count;

    function automatic csr_word_t apply_mask(input csr_word_t old_value, input csr_word_t mask,
                                             input csr_word_t value);
        return (value & mask) | (old_value & ~mask);
    endfunction

    function automatic int_vec_t model_is();
        return {is_ipi, is_timer, 1'b0, is_hw, is_sw};
    endfunction

    function automatic csr_word_t expected_read(input csr_num_t num);
        case (num)
            CSR_CRMD:   return {29'd0, ie, plv};
            CSR_PRMD:   return {29'd0, pie, pplv};
            CSR_ECFG:   return {19'd0, lie};
            CSR_ESTAT:  return {1'b0, esub, ecode, 3'd0, model_is()};
            CSR_ERA:    return era;
            CSR_BADV:   return badv;
            CSR_EENTRY: return eentry;
            CSR_SAVE0:  return save0;
            CSR_SAVE1:  return save1;
            CSR_SAVE2:  return save2;
            CSR_SAVE3:  return save3;
            CSR_TCFG:   return tcfg;
            CSR_TVAL:   return count;
            default:    return 32'd0;
        endcase
    endfunction

    function automatic string test_label(input int id);
        case (id)
            1:       return "masked read and write";
            2:       return "exception entry";
            3:       return "exception return";
            4:       return "one-shot timer";
            5:       return "periodic timer";
            6:       return "interrupt decision";
            default: return "unknown";
        endcase
    endfunction

    task automatic report_error(input string msg);
        $display("** Error at time %0t: %s", $time, msg);
        mismatch_count++;
        test_errors++;
    endtask

    task automatic compare_outputs();
        csr_word_t exp_rvalue;
        logic      exp_has_int;
        exp_rvalue  = expected_read(csr_num);
        exp_has_int = ie && (|(model_is() & lie));
        if (csr_rvalue !== exp_rvalue) begin
            report_error($sformatf("csr_rvalue of CSR 0x%0h is 0x%08h, expected 0x%08h",
                                   csr_num, csr_rvalue, exp_rvalue));
        end
        if (ex_entry !== eentry) begin
            report_error($sformatf("ex_entry is 0x%08h, expected 0x%08h", ex_entry, eentry));
        end
        if (has_int !== exp_has_int) begin
            report_error($sformatf("has_int is %b, expected %b", has_int, exp_has_int));
        end
    endtask

    task automatic close_test();
        if (test_errors == 0) begin
            passed_count++;
            $display("Test %0d, %s: passed", test_id, test_label(test_id));
        end else begin
            failed_count++;
            $display("Test %0d, %s: failed with %0d mismatches",
                     test_id, test_label(test_id), test_errors);
        end
        test_errors = 0;
    endtask

    task automatic reset_model();
        plv      = '0;
        ie       = 1'b0;
        pplv     = '0;
        pie      = 1'b0;
        ecode    = '0;
        esub     = '0;
        era      = '0;
        badv     = '0;
        eentry   = '0;
        save0    = '0;
        save1    = '0;
        save2    = '0;
        save3    = '0;
        tcfg     = '0;
        count    = TIMER_IDLE;
        lie      = '0;
        is_sw    = '0;
        is_hw    = '0;
        is_timer = 1'b0;
        is_ipi   = 1'b0;
        model_valid = 1'b1;
    endtask

    task automatic advance_model();
        csr_word_t merged;
        logic      fire;
        logic      clear;
        plv_t      old_plv;
        logic      old_ie;
        merged  = apply_mask(expected_read(csr_num), csr_wmask, csr_wvalue);
        fire    = tcfg[TCFG_EN_BIT] && (count == 32'd0);
        clear   = csr_we && (csr_num == CSR_TICLR) && merged[TICLR_CLR_BIT];
        old_plv = plv;
        old_ie  = ie;

        // Counter works from the TCFG value before this edge
        if (csr_we && csr_num == CSR_TCFG && merged[TCFG_EN_BIT]) begin
            count = {merged[31:2], 2'b00};
        end else if (tcfg[TCFG_EN_BIT] && count != TIMER_IDLE) begin
            if (count == 32'd0 && tcfg[TCFG_PERIODIC_BIT]) begin
                count = {tcfg[31:2], 2'b00};
            end else begin
                count = count - 32'd1;
            end
        end
        if (fire) begin
            is_timer = 1'b1;
        end else if (clear) begin
            is_timer = 1'b0;
        end
        is_hw  = hw_int_in;
        is_ipi = ipi_int_in;

        if (wb_ex) begin
            plv   = '0;
            ie    = 1'b0;
            pplv  = old_plv;
            pie   = old_ie;
            ecode = wb_ecode;
            esub  = wb_esubcode;
            era   = wb_pc;
            if (wb_ecode == ECODE_ADE && wb_esubcode == ESUBCODE_ADEF) begin
                badv = wb_pc;
            end else if (wb_ecode == ECODE_ADE || wb_ecode == ECODE_ALE) begin
                badv = wb_vaddr;
            end
        end else if (ertn_flush) begin
            plv = pplv;
            ie  = pie;
        end

        if (csr_we) begin
            case (csr_num)
                CSR_CRMD: begin
                    if (!wb_ex && !ertn_flush) begin
                        plv = merged[1:0];
                        ie  = merged[2];
                    end
                end
                CSR_PRMD: begin
                    if (!wb_ex) begin
                        pplv = merged[1:0];
                        pie  = merged[2];
                    end
                end
                CSR_ERA: begin
                    if (!wb_ex) begin
                        era = merged;
                    end
                end
                CSR_BADV: begin
                    if (!wb_ex) begin
                        badv = merged;
                    end
                end
                CSR_ECFG:   lie = merged[12:0] & ECFG_LIE_MASK[12:0];
                CSR_ESTAT:  is_sw = merged[1:0];
                CSR_EENTRY: eentry = {merged[31:6], 6'd0};
                CSR_SAVE0:  save0 = merged;
                CSR_SAVE1:  save1 = merged;
                CSR_SAVE2:  save2 = merged;
                CSR_SAVE3:  save3 = merged;
                CSR_TCFG:   tcfg = merged;
                default:    ;
            endcase
        end
    endtask

    // Inputs change at the rising edge, so both halves are settled here
    always @(negedge clk) begin
        if (model_valid) begin
            compare_outputs();
        end
        if (test_end) begin
            close_test();
        end
        if (!resetn) begin
            reset_model();
        end else if (model_valid) begin
            advance_model();
        end
    end

endmodule

// File: sim/tb_top.sv
module tb_top;
    import csr_pkg::*;

    logic        clk;
    logic        resetn;
    csr_num_t    csr_num;
    logic        csr_we;
    csr_word_t   csr_wmask;
    csr_word_t   csr_wvalue;
    logic        wb_ex;
    logic        ertn_flush;
    ecode_t      wb_ecode;
    esubcode_t   wb_esubcode;
    csr_word_t   wb_pc;
    csr_word_t   wb_vaddr;
    logic [7:0]  hw_int_in;
    logic        ipi_int_in;
    csr_word_t   csr_rvalue;
    csr_word_t   ex_entry;
    logic        has_int;
    logic        test_end;
    int          test_id;
    int          tests_passed;
    int          tests_failed;
    int          error_count;
    logic [31:0] lcg_state;

    csr_top i_dut (.*);

    csr_checker i_checker (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 15);
    endfunction

    function automatic csr_num_t pick_rw_reg(input logic [3:0] k);
        case (k)
            4'd0:    return CSR_CRMD;
            4'd1:    return CSR_PRMD;
            4'd2:    return CSR_ERA;
            4'd3:    return CSR_EENTRY;
            4'd4:    return CSR_SAVE0;
            4'd5:    return CSR_SAVE1;
            4'd6:    return CSR_SAVE2;
            4'd7:    return CSR_SAVE3;
            default: return CSR_ECFG;
        endcase
    endfunction

    task automatic drive_cycle(input csr_num_t num, input logic we, input csr_word_t mask,
                               input csr_word_t value);
        @(posedge clk);
        csr_num    <= num;
        csr_we     <= we;
        csr_wmask  <= mask;
        csr_wvalue <= value;
        wb_ex      <= 1'b0;
        ertn_flush <= 1'b0;
    endtask

    task automatic write_csr(input csr_num_t num, input csr_word_t mask, input csr_word_t value);
        drive_cycle(num, 1'b1, mask, value);
    endtask

    task automatic read_csr(input csr_num_t num);
        drive_cycle(num, 1'b0, next_random(), next_random());
    endtask

    // Exception and ertn can share the cycle with a software write
    task automatic pipeline_event(input logic ex, input logic ertn, input logic we,
                                  input csr_num_t num);
        logic [31:0] pick;
        pick = next_random();
        @(posedge clk);
        wb_ex       <= ex;
        ertn_flush  <= ertn;
        wb_ecode    <= (pick[1:0] == 2'd0) ? ECODE_ADE :
                       (pick[1:0] == 2'd1) ? ECODE_ALE : pick[7:2];
        wb_esubcode <= {8'd0, pick[8]};
        wb_pc       <= next_random();
        wb_vaddr    <= next_random();
        csr_num     <= num;
        csr_we      <= we;
        csr_wmask   <= next_random();
        csr_wvalue  <= next_random();
    endtask

    task automatic wait_timer_irq(input int limit);
        logic seen;
        seen = 1'b0;
        read_csr(CSR_ESTAT);
        for (int i = 0; i < limit && !seen; i++) begin
            @(negedge clk);
            seen = csr_rvalue[TIMER_IRQ_BIT];
        end
        if (!seen) begin
            $display("Timeout: timer interrupt bit not set within %0d cycles", limit);
            $display("STATUS: FAIL");
            $finish;
        end
    endtask

    task automatic end_test(input int id);
        @(posedge clk);
        csr_we   <= 1'b0;
        test_end <= 1'b1;
        test_id  <= id;
        @(posedge clk);
        test_end <= 1'b0;
    endtask

    initial begin
        logic [31:0] rnd;
        logic [29:0] initv;
        lcg_state = 32'd21;
        resetn      <= 1'b0;
        csr_num     <= '0;
        csr_we      <= 1'b0;
        csr_wmask   <= '0;
        csr_wvalue  <= '0;
        wb_ex       <= 1'b0;
        ertn_flush  <= 1'b0;
        wb_ecode    <= '0;
        wb_esubcode <= '0;
        wb_pc       <= '0;
        wb_vaddr    <= '0;
        hw_int_in   <= '0;
        ipi_int_in  <= 1'b0;
        test_end    <= 1'b0;
        test_id     <= 0;
        repeat (2) @(posedge clk);
        resetn <= 1'b1;

        for (int i = 0; i < 40; i++) begin
            rnd = next_random();
            write_csr(pick_rw_reg(rnd[3:0] % 4'd9), next_random(), next_random());
            read_csr(pick_rw_reg(rnd[3:0] % 4'd9));
            read_csr(rnd[29:16]);
        end
        end_test(1);

        for (int i = 0; i < 24; i++) begin
            write_csr(CSR_CRMD, 32'h7, next_random());
            if (i % 4 == 0) begin
                write_csr(CSR_EENTRY, '1, next_random());
            end
            pipeline_event(1'b1, 1'b0, 1'b1, CSR_ERA);
            read_csr(CSR_CRMD);
            read_csr(CSR_PRMD);
            read_csr(CSR_ERA);
            read_csr(CSR_ESTAT);
            read_csr(CSR_BADV);
        end
        end_test(2);

        for (int i = 0; i < 16; i++) begin
            rnd = next_random();
            write_csr(CSR_PRMD, '1, next_random());
            pipeline_event(1'b0, 1'b1, rnd[0], CSR_CRMD);
            read_csr(CSR_CRMD);
            pipeline_event(1'b1, 1'b1, 1'b1, CSR_CRMD);
            read_csr(CSR_CRMD);
            read_csr(CSR_PRMD);
            pipeline_event(1'b1, 1'b0, 1'b1, CSR_PRMD);
            read_csr(CSR_PRMD);
        end
        end_test(3);

        rnd = next_random();
        initv = {27'd0, rnd[2:0]} + 30'd2;
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        write_csr(CSR_TCFG, '1, {initv, 2'b01});
        repeat (4) read_csr(CSR_TVAL);
        wait_timer_irq(200);
        repeat (2) read_csr(CSR_TVAL);
        write_csr(CSR_TICLR, '1, 32'h1);
        repeat (2) read_csr(CSR_ESTAT);
        end_test(4);

        write_csr(CSR_TCFG, '1, {initv, 2'b11});
        wait_timer_irq(200);
        repeat (3) read_csr(CSR_TVAL);
        repeat (3) read_csr(CSR_ESTAT);
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        read_csr(CSR_ESTAT);
        wait_timer_irq(200);
        write_csr(CSR_TCFG, 32'h1, 32'h0);
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        read_csr(CSR_ESTAT);
        end_test(5);

        for (int i = 0; i < 80; i++) begin
            rnd = next_random();
            case (rnd[11:10])
                2'd0:    write_csr(CSR_ECFG, next_random(), next_random());
                2'd1:    write_csr(CSR_ESTAT, next_random(), next_random());
                2'd2:    write_csr(CSR_CRMD, 32'h4, next_random());
                default: read_csr(CSR_ESTAT);
            endcase
            hw_int_in  <= rnd[7:0];
            ipi_int_in <= rnd[8];
        end
        @(posedge clk);
        hw_int_in  <= '0;
        ipi_int_in <= 1'b0;
        end_test(6);

        repeat (2) @(posedge clk);
        $display("Tests passed: %0d, tests failed: %0d, mismatches: %0d",
                 tests_passed, tests_failed, error_count);
        if (tests_passed == 6 && tests_failed == 0 && error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
verilog/csr_pkg.sv
verilog/csr_exc_regs.sv
verilog/csr_timer.sv
verilog/csr_int_ctrl.sv
verilog/csr_read_mux.sv
verilog/csr_top.sv
sim/csr_checker.sv
sim/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the CSR block testbench with Verilator
set -u
cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary -j 0 --top-module tb_top -f src.f -Mdir "$BUILD_DIR" -o tb_top
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"./$BUILD_DIR/tb_top" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "STATUS: FAIL" "$LOG_FILE"; then
    echo "Simulation reported a failure"
    exit 1
fi
exit 0
